// ==== src/scratch_pkg.sv ====
/*
 * Shared definitions for the two-bank scratchpad.
 * Contains the word, address and counter widths, the bank geometry
 * and the vector typedefs used by every block.
 */

package scratch_pkg;

   // Width of one stored data word.
   localparam int WORD_W = 32;

   // The scratchpad is split evenly over two single-port banks.
   localparam int BANK_ELS  = 48;
   localparam int NUM_BANKS = 2;
   localparam int TOTAL_ELS = NUM_BANKS * BANK_ELS;

   // Request addresses cover a power-of-two space, so the top of the
   // range (96 to 127) is decoded as out of range.
   localparam int ADDR_W      = $clog2(TOTAL_ELS);
   localparam int BANK_ADDR_W = $clog2(BANK_ELS);

   // Event counters saturate at all ones.
   localparam int CNT_W = 16;

   typedef logic [WORD_W-1:0]      word_t;
   typedef logic [ADDR_W-1:0]      addr_t;
   typedef logic [BANK_ADDR_W-1:0] bank_addr_t;
   typedef logic [CNT_W-1:0]       count_t;

endpackage : scratch_pkg

// ==== src/scratch_bank_if.sv ====
/*
 * Request and read-data bundle for one scratchpad bank.
 * The controller side drives the request; the bank side returns
 * read data one cycle after a read.
 */

`timescale 1ns/1ps

interface scratch_bank_if import scratch_pkg::*; ();

   logic       v;
   logic       w;
   bank_addr_t addr;
   word_t      wdata;
   word_t      rdata;

   // Controller view.
   modport ctrl (
      output v, w, addr, wdata,
      input  rdata
   );

   // Bank view.
   modport bank (
      input  v, w, addr, wdata,
      output rdata
   );

endinterface : scratch_bank_if

// ==== src/mem_1rw_sync.sv ====
/*
 * Synchronous single-port RAM.
 * One read or one write per cycle. The read address is registered,
 * so read data appears in the cycle after the read request.
 * Contains a range check on incoming addresses.
 */

`timescale 1ns/1ps

module mem_1rw_sync import scratch_pkg::*;
#(
   parameter int width_p = WORD_W,
   parameter int els_p   = BANK_ELS
)
(
   input logic           clk_i,
   input logic           reset_i,
   scratch_bank_if.bank  bank_if
);

   logic [width_p-1:0] mem [els_p];
   bank_addr_t         addr_r;
   logic               read_en;
   logic               write_en;

   assign read_en  = bank_if.v & ~bank_if.w;
   assign write_en = bank_if.v &  bank_if.w;

   // The array itself has no reset; contents are undefined until written.
   always_ff @(posedge clk_i)
   begin
      if (write_en)
      begin
         mem[bank_if.addr] <= bank_if.wdata;
      end
   end

   // Capture the address only on a read. The array output then follows
   // the registered address during the next cycle.
   always_ff @(posedge clk_i)
   begin
      if (read_en)
      begin
         addr_r <= bank_if.addr;
      end
   end

   assign bank_if.rdata = mem[addr_r];

   // The controller subtracts the bank base before it drives a bank, so any
   // address at or above els_p here points to a decode fault upstream.
   a_addr_in_range : assert property (
      @(posedge clk_i) disable iff (reset_i)
      bank_if.v |-> (bank_if.addr < els_p)
   )
   else $error("mem_1rw_sync: address %0d outside %0d words", bank_if.addr, els_p);

endmodule : mem_1rw_sync

// ==== src/scratch_cfg_regs.sv ====
/*
 * Configuration and status registers for the scratchpad.
 * Holds the write-protect limit and two saturating event counters:
 * one for blocked writes and one for out-of-range requests.
 * Clear zeroes both counters and wins over a same-cycle increment.
 */

`timescale 1ns/1ps

module scratch_cfg_regs import scratch_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,

   input  logic   limit_we_i,
   input  addr_t  limit_i,
   input  logic   clear_i,

   input  logic   blocked_wr_i,
   input  logic   range_err_i,

   output addr_t  protect_limit_o,
   output count_t blocked_cnt_o,
   output count_t range_err_cnt_o
);

   addr_t  limit_r;
   count_t blocked_cnt_r;
   count_t range_err_cnt_r;

   // Increment by one on an event, stopping at all ones.
   function automatic count_t sat_inc(input count_t cnt, input logic event_v);
      count_t result;
      result = cnt;
      if (event_v && (cnt != '1))
      begin
         result = cnt + count_t'(1);
      end
      return result;
   endfunction

   // A new limit applies to requests from the following cycle on.
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         limit_r <= '0;
      end
      else if (limit_we_i)
      begin
         limit_r <= limit_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i || clear_i)
      begin
         blocked_cnt_r   <= '0;
         range_err_cnt_r <= '0;
      end
      else
      begin
         blocked_cnt_r   <= sat_inc(blocked_cnt_r, blocked_wr_i);
         range_err_cnt_r <= sat_inc(range_err_cnt_r, range_err_i);
      end
   end

   assign protect_limit_o = limit_r;
   assign blocked_cnt_o   = blocked_cnt_r;
   assign range_err_cnt_o = range_err_cnt_r;

   // Counters only move upward between clears.
   a_blocked_monotonic : assert property (
      @(posedge clk_i) disable iff (reset_i)
      !clear_i |=> (blocked_cnt_r >= $past(blocked_cnt_r))
   );

   a_range_monotonic : assert property (
      @(posedge clk_i) disable iff (reset_i)
      !clear_i |=> (range_err_cnt_r >= $past(range_err_cnt_r))
   );

endmodule : scratch_cfg_regs

// ==== src/scratch_bank_ctrl.sv ====
/*
 * Front-end controller for the two-bank scratchpad.
 * Decodes each request to a bank, drops protected writes and
 * out-of-range requests, and steers the rest to one bank.
 * Tracks reads in flight and holds the last read word for the host.
 */

`timescale 1ns/1ps

module scratch_bank_ctrl import scratch_pkg::*;
(
   input  logic          clk_i,
   input  logic          reset_i,

   input  logic          req_v_i,
   input  logic          req_w_i,
   input  addr_t         req_addr_i,
   input  word_t         req_wdata_i,

   input  addr_t         protect_limit_i,

   scratch_bank_if.ctrl  bank0_if,
   scratch_bank_if.ctrl  bank1_if,

   output logic          blocked_wr_o,
   output logic          range_err_o,

   output word_t         rdata_o,
   output logic          rvalid_o
);

   logic       in_range;
   logic       hi_bank;
   logic       blocked;
   logic       accept;
   logic       rd_issue;
   bank_addr_t bank_addr;

   logic       rd_pend_r;
   logic       rd_bank_r;
   logic       rd_oor_r;
   word_t      hold_r;
   logic       rvalid_r;

   assign in_range = (req_addr_i < addr_t'(TOTAL_ELS));
   assign hi_bank  = (req_addr_i >= addr_t'(BANK_ELS));

   // Bank 1 starts at BANK_ELS, so its local address drops the base.
   assign bank_addr = hi_bank ? bank_addr_t'(req_addr_i - addr_t'(BANK_ELS))
                              : bank_addr_t'(req_addr_i);

   // A range error takes precedence, so a protected write that is also
   // out of range is counted only once.
   assign blocked  = req_v_i & req_w_i & in_range & (req_addr_i < protect_limit_i);
   assign accept   = req_v_i & in_range & ~blocked;
   assign rd_issue = req_v_i & ~req_w_i;

   assign blocked_wr_o = blocked;
   assign range_err_o  = req_v_i & ~in_range;

   // Both banks see the same payload; only the selected one gets v.
   assign bank0_if.v     = accept & ~hi_bank;
   assign bank0_if.w     = req_w_i;
   assign bank0_if.addr  = bank_addr;
   assign bank0_if.wdata = req_wdata_i;

   assign bank1_if.v     = accept & hi_bank;
   assign bank1_if.w     = req_w_i;
   assign bank1_if.addr  = bank_addr;
   assign bank1_if.wdata = req_wdata_i;

   // Remember where each read went. Out-of-range reads still return a result.
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_pend_r <= 1'b0;
      end
      else
      begin
         rd_pend_r <= rd_issue;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rd_issue)
      begin
         rd_bank_r <= hi_bank;
         rd_oor_r  <= ~in_range;
      end
   end

   // The bank output is only valid for one cycle, so it is captured here
   // and held until the next read completes.
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         hold_r   <= '0;
         rvalid_r <= 1'b0;
      end
      else
      begin
         rvalid_r <= rd_pend_r;
         if (rd_pend_r)
         begin
            hold_r <= rd_oor_r  ? '0 :
                      rd_bank_r ? bank1_if.rdata : bank0_if.rdata;
         end
      end
   end

   assign rdata_o  = hold_r;
   assign rvalid_o = rvalid_r;

   // Only one bank may be driven per cycle.
   a_one_bank : assert property (
      @(posedge clk_i) disable iff (reset_i)
      !(bank0_if.v && bank1_if.v)
   );

endmodule : scratch_bank_ctrl

// ==== src/scratch_top.sv ====
/*
 * Scratchpad top level.
 * Connects the controller, the configuration block and the two
 * single-port banks. All external signals are plain ports.
 */

`timescale 1ns/1ps

module scratch_top import scratch_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,

   input  logic   req_v_i,
   input  logic   req_w_i,
   input  addr_t  req_addr_i,
   input  word_t  req_wdata_i,

   output word_t  rdata_o,
   output logic   rvalid_o,

   input  logic   cfg_limit_we_i,
   input  addr_t  cfg_limit_i,
   input  logic   cfg_clear_i,

   output count_t blocked_cnt_o,
   output count_t range_err_cnt_o
);

   addr_t protect_limit;
   logic  blocked_wr;
   logic  range_err;

   scratch_bank_if bank0_if ();
   scratch_bank_if bank1_if ();

   scratch_bank_ctrl u_ctrl (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .req_v_i         (req_v_i),
      .req_w_i         (req_w_i),
      .req_addr_i      (req_addr_i),
      .req_wdata_i     (req_wdata_i),
      .protect_limit_i (protect_limit),
      .bank0_if        (bank0_if.ctrl),
      .bank1_if        (bank1_if.ctrl),
      .blocked_wr_o    (blocked_wr),
      .range_err_o     (range_err),
      .rdata_o         (rdata_o),
      .rvalid_o        (rvalid_o)
   );

   scratch_cfg_regs u_cfg (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .limit_we_i      (cfg_limit_we_i),
      .limit_i         (cfg_limit_i),
      .clear_i         (cfg_clear_i),
      .blocked_wr_i    (blocked_wr),
      .range_err_i     (range_err),
      .protect_limit_o (protect_limit),
      .blocked_cnt_o   (blocked_cnt_o),
      .range_err_cnt_o (range_err_cnt_o)
   );

   mem_1rw_sync #(.width_p(WORD_W), .els_p(BANK_ELS)) u_bank0 (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .bank_if (bank0_if.bank)
   );

   mem_1rw_sync #(.width_p(WORD_W), .els_p(BANK_ELS)) u_bank1 (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .bank_if (bank1_if.bank)
   );

endmodule : scratch_top

// ==== tb/tb_clock_gen.sv ====
/*
 * Testbench clock and reset generator.
 * 10 ns clock; reset held high for the first 8 cycles.
 */

`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk_o,
   output logic reset_o
);

   localparam int HALF_PERIOD  = 5;
   localparam int RESET_CYCLES = 8;

   initial
   begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Reset drops on a falling edge, away from the edge the DUT samples.
   initial
   begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;
   end

endmodule : tb_clock_gen

// ==== tb/tb_scratch.sv ====
/*
 * Random-stimulus testbench for the two-bank scratchpad.
 * Contains the DUT instance, a cycle-level reference model,
 * typed compare tasks and bounded waits for reset and read results.
 */

`timescale 1ns/1ps

module tb_scratch import scratch_pkg::*; ();

   localparam int RST_TIMEOUT = 50;
   localparam int RD_TIMEOUT  = 6;
   localparam int SEED        = 41799;

   logic   clk;
   logic   reset;
   logic   req_v;
   logic   req_w;
   addr_t  req_addr;
   word_t  req_wdata;
   word_t  rdata;
   logic   rvalid;
   logic   cfg_limit_we;
   addr_t  cfg_limit;
   logic   cfg_clear;
   count_t blocked_cnt;
   count_t range_err_cnt;

   // Reference model state, updated once per rising edge.
   word_t  mem_m [TOTAL_ELS];
   addr_t  limit_m;
   count_t blocked_m;
   count_t range_m;
   word_t  hold_m;
   logic   rvalid_m;
   logic   pend_m;
   word_t  pend_data_m;
   logic   seen_valid;
   int     err_cnt;

   tb_clock_gen u_clk_gen (.clk_o(clk), .reset_o(reset));

   scratch_top u_dut (
      .clk_i           (clk),
      .reset_i         (reset),
      .req_v_i         (req_v),
      .req_w_i         (req_w),
      .req_addr_i      (req_addr),
      .req_wdata_i     (req_wdata),
      .rdata_o         (rdata),
      .rvalid_o        (rvalid),
      .cfg_limit_we_i  (cfg_limit_we),
      .cfg_limit_i     (cfg_limit),
      .cfg_clear_i     (cfg_clear),
      .blocked_cnt_o   (blocked_cnt),
      .range_err_cnt_o (range_err_cnt)
   );

   task automatic stop_run();
      err_cnt++;
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input count_t got, input count_t exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   // Outputs are compared on the falling edge, half a cycle after they change.
   task automatic compare_outputs();
      check_flag("rvalid_o", rvalid, rvalid_m);
      check_word("rdata_o", rdata, hold_m);
      check_count("blocked_cnt_o", blocked_cnt, blocked_m);
      check_count("range_err_cnt_o", range_err_cnt, range_m);
      seen_valid = rvalid;
   endtask

   // Applies the request rules to the inputs sampled at this rising edge.
   task automatic model_edge();
      logic in_rng;
      logic blk;
      logic oor;
      rvalid_m = pend_m;
      if (pend_m)
      begin
         hold_m = pend_data_m;
      end
      pend_m = 1'b0;
      in_rng = (req_addr < addr_t'(TOTAL_ELS));
      oor    = req_v && !in_rng;
      blk    = req_v && req_w && in_rng && (req_addr < limit_m);
      if (req_v && !req_w)
      begin
         pend_m      = 1'b1;
         pend_data_m = in_rng ? mem_m[req_addr] : '0;
      end
      if (req_v && req_w && in_rng && !blk)
      begin
         mem_m[req_addr] = req_wdata;
      end
      if (cfg_clear)
      begin
         blocked_m = '0;
         range_m   = '0;
      end
      else
      begin
         if (blk && (blocked_m != '1))
            blocked_m = blocked_m + count_t'(1);
         if (oor && (range_m != '1))
            range_m = range_m + count_t'(1);
      end
      if (cfg_limit_we)
      begin
         limit_m = cfg_limit;
      end
   endtask

   task automatic run_cycle(input logic v, input logic w, input addr_t addr, input word_t wdata,
                            input logic lim_we, input addr_t lim, input logic clr);
      @(negedge clk);
      compare_outputs();
      req_v        = v;
      req_w        = w;
      req_addr     = addr;
      req_wdata    = wdata;
      cfg_limit_we = lim_we;
      cfg_limit    = lim;
      cfg_clear    = clr;
      @(posedge clk);
      model_edge();
   endtask

   task automatic idle_cycle();
      run_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
   endtask

   task automatic write_word(input addr_t addr, input word_t data);
      run_cycle(1'b1, 1'b1, addr, data, 1'b0, '0, 1'b0);
   endtask

   task automatic read_word(input addr_t addr);
      run_cycle(1'b1, 1'b0, addr, word_t'($urandom), 1'b0, '0, 1'b0);
   endtask

   task automatic set_limit(input addr_t lim);
      run_cycle(1'b0, 1'b0, '0, '0, 1'b1, lim, 1'b0);
   endtask

   // The leading idle cycle lets any earlier read result pass first.
   task automatic read_and_wait(input addr_t addr);
      int waited;
      idle_cycle();
      read_word(addr);
      waited     = 0;
      seen_valid = 1'b0;
      while (!seen_valid)
      begin
         if (waited == RD_TIMEOUT)
         begin
            $display("Timeout: no read result for address 0x%h after %0d cycles", addr, waited);
            stop_run();
         end
         idle_cycle();
         waited++;
      end
   endtask

   task automatic random_op(input int lo, input int hi);
      int    op;
      addr_t addr;
      op   = $urandom_range(3, 0);
      addr = addr_t'($urandom_range(hi, lo));
      case (op)
         0: idle_cycle();
         1: write_word(addr, word_t'($urandom));
         default: read_word(addr);
      endcase
   endtask

   initial
   begin
      int    waited;
      addr_t lim;
      req_v        = 1'b0;
      req_w        = 1'b0;
      req_addr     = '0;
      req_wdata    = '0;
      cfg_limit_we = 1'b0;
      cfg_limit    = '0;
      cfg_clear    = 1'b0;
      limit_m      = '0;
      blocked_m    = '0;
      range_m      = '0;
      hold_m       = '0;
      rvalid_m     = 1'b0;
      pend_m       = 1'b0;
      pend_data_m  = '0;
      seen_valid   = 1'b0;
      err_cnt      = 0;
      void'($urandom(SEED));

      waited = 0;
      while (reset !== 1'b0)
      begin
         if (waited == RST_TIMEOUT)
         begin
            $display("Timeout: reset still asserted after %0d cycles", waited);
            stop_run();
         end
         @(posedge clk);
         waited++;
      end

      // Fill every address, then mix reads, writes and idle cycles.
      for (int a = 0; a < TOTAL_ELS; a++)
         write_word(addr_t'(a), word_t'($urandom));
      for (int i = 0; i < 400; i++)
         random_op(0, TOTAL_ELS - 1);
      read_and_wait(addr_t'(0));
      read_and_wait(addr_t'(TOTAL_ELS - 1));

      // Write protection below a random limit.
      lim = addr_t'($urandom_range(80, 16));
      set_limit(lim);
      for (int i = 0; i < 200; i++)
         random_op(0, TOTAL_ELS - 1);
      write_word(lim - addr_t'(1), word_t'($urandom));
      read_and_wait(lim - addr_t'(1));
      set_limit('0);

      // Out-of-range requests, including one that is also protected.
      for (int i = 0; i < 100; i++)
         random_op(TOTAL_ELS, 127);
      read_and_wait(addr_t'(100));
      set_limit(addr_t'(127));
      write_word(addr_t'(110), word_t'($urandom));
      write_word(addr_t'(5), word_t'($urandom));
      set_limit('0);

      // Every in-range word must have survived the dropped requests above.
      for (int a = 0; a < TOTAL_ELS; a++)
         read_word(addr_t'(a));

      // Bank boundary with back-to-back alternating reads.
      write_word(addr_t'(47), word_t'($urandom));
      write_word(addr_t'(48), word_t'($urandom));
      read_word(addr_t'(47));
      read_word(addr_t'(48));
      read_word(addr_t'(47));
      read_word(addr_t'(48));
      read_and_wait(addr_t'(48));

      // Clear wins over a counted event in the same cycle.
      set_limit(addr_t'(50));
      run_cycle(1'b1, 1'b1, addr_t'(10), word_t'($urandom), 1'b0, '0, 1'b1);
      write_word(addr_t'(20), word_t'($urandom));
      run_cycle(1'b1, 1'b0, addr_t'(120), '0, 1'b0, '0, 1'b1);
      repeat (3) idle_cycle();

      if (err_cnt == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule : tb_scratch

// ==== filelist.f ====
src/scratch_pkg.sv
src/scratch_bank_if.sv
src/mem_1rw_sync.sv
src/scratch_cfg_regs.sv
src/scratch_bank_ctrl.sv
src/scratch_top.sv
tb/tb_clock_gen.sv
tb/tb_scratch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the scratchpad testbench with Verilator and runs it.
# The run fails when the log holds the testbench's failure line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="ERRORS FOUND"

verilator --binary --assert -Wno-fatal \
   --top-module tb_scratch \
   -f filelist.f \
   --Mdir "$BUILD_DIR" \
   -o Vtb_scratch
if [ $? -ne 0 ]; then
   echo "Verilator build failed."
   exit 1
fi

"./$BUILD_DIR/Vtb_scratch" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
   echo "Simulation reported a failure."
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status."
   exit 1
fi

echo "Simulation finished cleanly."
exit 0
